// File: design/mem_pkg.sv
package mem_pkg;

  // Core data and address width
  parameter int xlen = 32;

  // Load/store size code, funct3 of the instruction
  typedef logic [2:0] funct3_t;

  localparam funct3_t funct3_b  = 3'b000;  // lb / sb
  localparam funct3_t funct3_h  = 3'b001;  // lh / sh
  localparam funct3_t funct3_w  = 3'b010;  // lw / sw
  localparam funct3_t funct3_bu = 3'b100;  // lbu
  localparam funct3_t funct3_hu = 3'b101;  // lhu

  typedef enum logic {
    dram = 1'b0,
    mmio = 1'b1
  } region_t;

  // I/O register map
  localparam logic [xlen-1:0] mmio_uart_ctrl = 32'h8000_0000;
  localparam logic [xlen-1:0] mmio_uart_rx   = 32'h8000_0004;
  localparam logic [xlen-1:0] mmio_uart_tx   = 32'h8000_0008;
  localparam logic [xlen-1:0] mmio_cycle_cnt = 32'h8000_0010;
  localparam logic [xlen-1:0] mmio_inst_cnt  = 32'h8000_0014;
  localparam logic [xlen-1:0] mmio_cnt_reset = 32'h8000_0018;

  // Request from the execute stage
  typedef struct packed {
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
    funct3_t         funct3;
    logic            we;
    logic            re;
  } mem_req_t;

  // Travels with a load to the return path
  typedef struct packed {
    region_t    region;
    logic [1:0] byte_off;
    funct3_t    funct3;
  } load_tag_t;

  // Byte enables plus lane-aligned store data
  typedef struct packed {
    logic [3:0]      be;
    logic [xlen-1:0] data;
  } wr_lane_t;

endpackage

// File: design/store_format.sv
module store_format (
  input  mem_pkg::funct3_t         funct3,
  input  logic [1:0]               byte_offset,
  input  logic [mem_pkg::xlen-1:0] wdata,
  output mem_pkg::wr_lane_t        lane
);

  // Replicating the byte or half puts it in every lane,
  // so only the enables depend on the offset
  always_comb begin
    lane.be   = 4'b0000;
    lane.data = wdata;
    case (funct3)
      mem_pkg::funct3_b: begin
        lane.be   = 4'b0001 << byte_offset;
        lane.data = {4{wdata[7:0]}};
      end
      mem_pkg::funct3_h: begin
        // Half stores use the aligned half of the word
        lane.be   = byte_offset[1] ? 4'b1100 : 4'b0011;
        lane.data = {2{wdata[15:0]}};
      end
      mem_pkg::funct3_w: begin
        lane.be   = 4'b1111;
        lane.data = wdata;
      end
      default: begin
        lane.be   = 4'b0000;  // lbu/lhu codes are not stores
        lane.data = wdata;
      end
    endcase
  end

endmodule

// File: design/data_ram.sv
module data_ram #(
  parameter int dram_addr_width = 14
) (
  input  logic                       clk,
  input  logic [dram_addr_width-1:0] addr,
  input  mem_pkg::wr_lane_t          lane,
  output logic [mem_pkg::xlen-1:0]   rdata
);

  localparam int depth = 1 << dram_addr_width;

  logic [mem_pkg::xlen-1:0] mem [0:depth-1];

  // Read is registered every cycle
  // Same-cycle write shows the old word
  always_ff @(posedge clk) begin
    rdata <= mem[addr];
    for (int i = 0; i < 4; i++) begin
      if (lane.be[i]) begin
        mem[addr][8*i +: 8] <= lane.data[8*i +: 8];
      end
    end
  end

endmodule

// File: design/byte_fifo.sv
module byte_fifo #(
  parameter int fifo_log_depth = 5
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       enq_valid,
  output logic       enq_ready,
  input  logic [7:0] enq_data,
  output logic       deq_valid,
  input  logic       deq_ready,
  output logic [7:0] deq_data
);

  localparam logic [fifo_log_depth:0] depth = 1 << fifo_log_depth;

  logic [7:0]                buffer [0:depth-1];
  logic [fifo_log_depth-1:0] wr_ptr;
  logic [fifo_log_depth-1:0] rd_ptr;
  logic [fifo_log_depth:0]   count;
  logic                      enq_fire;
  logic                      deq_fire;

  assign enq_ready = (count != depth);
  assign deq_valid = (count != '0);
  assign deq_data  = buffer[rd_ptr];  // Head entry, no extra cycle

  assign enq_fire = enq_valid && enq_ready;
  assign deq_fire = deq_valid && deq_ready;

  always_ff @(posedge clk) begin
    if (enq_fire) begin
      buffer[wr_ptr] <= enq_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (enq_fire) wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
      if (deq_fire) rd_ptr <= rd_ptr + 1'b1;
      case ({enq_fire, deq_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: design/mmio_regs.sv
module mmio_regs #(
  parameter int fifo_log_depth = 5
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [mem_pkg::xlen-1:0] addr,
  input  logic [mem_pkg::xlen-1:0] wdata,
  input  logic                     we,
  input  logic                     re,
  input  logic [6:0]               opcode,
  output logic [mem_pkg::xlen-1:0] rdata,
  output logic [7:0]               tx_data,
  output logic                     tx_valid,
  input  logic                     tx_ready,
  input  logic [7:0]               rx_data,
  input  logic                     rx_valid,
  output logic                     rx_ready
);

  logic                     tx_enq;
  logic                     tx_room;
  logic                     rx_deq;
  logic                     rx_avail;
  logic [7:0]               rx_byte;
  logic                     cnt_clear;
  logic [mem_pkg::xlen-1:0] cycle_cnt;
  logic [mem_pkg::xlen-1:0] inst_cnt;
  logic [mem_pkg::xlen-1:0] read_word;

  // Register strobes
  assign tx_enq    = we && (addr == mem_pkg::mmio_uart_tx);
  assign rx_deq    = re && (addr == mem_pkg::mmio_uart_rx);
  assign cnt_clear = we && (addr == mem_pkg::mmio_cnt_reset);

  // A full tx FIFO drops the store
  byte_fifo #(
    .fifo_log_depth(fifo_log_depth)
  ) tx_fifo (
    .clk      (clk),
    .reset    (reset),
    .enq_valid(tx_enq),
    .enq_ready(tx_room),
    .enq_data (wdata[7:0]),
    .deq_valid(tx_valid),
    .deq_ready(tx_ready),
    .deq_data (tx_data)
  );

  byte_fifo #(
    .fifo_log_depth(fifo_log_depth)
  ) rx_fifo (
    .clk      (clk),
    .reset    (reset),
    .enq_valid(rx_valid),
    .enq_ready(rx_ready),
    .enq_data (rx_data),
    .deq_valid(rx_avail),
    .deq_ready(rx_deq),
    .deq_data (rx_byte)
  );

  // Both counters restart from zero after a counter-reset store
  always_ff @(posedge clk) begin
    if (reset || cnt_clear) begin
      cycle_cnt <= '0;
      inst_cnt  <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + 1'b1;
      if (opcode != 7'd0) inst_cnt <= inst_cnt + 1'b1;
    end
  end

  always_comb begin
    case (addr)
      mem_pkg::mmio_uart_ctrl: read_word = {30'd0, rx_avail, tx_room};
      mem_pkg::mmio_uart_rx:   read_word = {24'd0, rx_byte};
      mem_pkg::mmio_cycle_cnt: read_word = cycle_cnt;
      mem_pkg::mmio_inst_cnt:  read_word = inst_cnt;
      default:                 read_word = '0;  // Unmapped reads as zero
    endcase
  end

  always_ff @(posedge clk) begin
    rdata <= read_word;
  end

endmodule

// File: design/load_align.sv
module load_align (
  input  mem_pkg::load_tag_t       tag,
  input  logic [mem_pkg::xlen-1:0] dram_rdata,
  input  logic [mem_pkg::xlen-1:0] mmio_rdata,
  output logic [mem_pkg::xlen-1:0] load_data
);

  logic [mem_pkg::xlen-1:0] word;
  logic [mem_pkg::xlen-1:0] shifted;
  logic [7:0]               byte_val;
  logic [15:0]              half_val;

  // Anything not decoded as I/O returns the RAM word
  assign word = (tag.region == mem_pkg::mmio) ? mmio_rdata : dram_rdata;

  assign shifted  = word >> {tag.byte_off, 3'b000};
  assign byte_val = shifted[7:0];

  // Halves come from the aligned half, as stores write them
  assign half_val = tag.byte_off[1] ? word[31:16] : word[15:0];

  always_comb begin
    case (tag.funct3)
      mem_pkg::funct3_b: begin
        load_data = {{24{byte_val[7]}}, byte_val};
      end
      mem_pkg::funct3_h: begin
        load_data = {{16{half_val[15]}}, half_val};
      end
      mem_pkg::funct3_bu: begin
        load_data = {24'd0, byte_val};
      end
      mem_pkg::funct3_hu: begin
        load_data = {16'd0, half_val};
      end
      default: begin
        load_data = word;  // lw and unused codes
      end
    endcase
  end

endmodule

// File: design/mem_stage.sv
module mem_stage #(
  parameter int dram_addr_width = 14,
  parameter int fifo_log_depth  = 5
) (
  input  logic                     clk,
  input  logic                     reset,
  input  mem_pkg::mem_req_t        req,
  input  logic [6:0]               opcode,
  output logic [mem_pkg::xlen-1:0] load_data,
  output logic                     load_valid,
  output logic [7:0]               tx_data,
  output logic                     tx_valid,
  input  logic                     tx_ready,
  input  logic [7:0]               rx_data,
  input  logic                     rx_valid,
  output logic                     rx_ready
);

  logic                     is_dram;
  logic                     is_mmio;
  mem_pkg::wr_lane_t        fmt_lane;
  mem_pkg::wr_lane_t        ram_lane;
  logic [mem_pkg::xlen-1:0] dram_rdata;
  logic [mem_pkg::xlen-1:0] mmio_rdata;
  mem_pkg::load_tag_t       tag_q;

  // Top nibble 0001 or 0011 is data memory, bit 31 is I/O
  assign is_dram = (req.addr[31:28] & 4'b1101) == 4'b0001;
  assign is_mmio = req.addr[31];

  store_format store_format_inst (
    .funct3     (req.funct3),
    .byte_offset(req.addr[1:0]),
    .wdata      (req.wdata),
    .lane       (fmt_lane)
  );

  // Writes outside the RAM window never reach it
  assign ram_lane.be   = (req.we && is_dram) ? fmt_lane.be : 4'b0000;
  assign ram_lane.data = fmt_lane.data;

  data_ram #(
    .dram_addr_width(dram_addr_width)
  ) data_ram_inst (
    .clk  (clk),
    .addr (req.addr[dram_addr_width+1:2]),
    .lane (ram_lane),
    .rdata(dram_rdata)
  );

  mmio_regs #(
    .fifo_log_depth(fifo_log_depth)
  ) mmio_regs_inst (
    .clk     (clk),
    .reset   (reset),
    .addr    (req.addr),
    .wdata   (fmt_lane.data),
    .we      (req.we && is_mmio),
    .re      (req.re && is_mmio),
    .opcode  (opcode),
    .rdata   (mmio_rdata),
    .tx_data (tx_data),
    .tx_valid(tx_valid),
    .tx_ready(tx_ready),
    .rx_data (rx_data),
    .rx_valid(rx_valid),
    .rx_ready(rx_ready)
  );

  // Tag lines up with the one-cycle memory reads
  always_ff @(posedge clk) begin
    if (req.re) begin
      tag_q.region   <= is_mmio ? mem_pkg::mmio : mem_pkg::dram;
      tag_q.byte_off <= req.addr[1:0];
      tag_q.funct3   <= req.funct3;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) load_valid <= 1'b0;
    else       load_valid <= req.re;
  end

  load_align load_align_inst (
    .tag       (tag_q),
    .dram_rdata(dram_rdata),
    .mmio_rdata(mmio_rdata),
    .load_data (load_data)
  );

endmodule

// File: tb/mem_stage_checker.sv
module mem_stage_checker (
  input logic              clk,
  input logic              reset,
  input mem_pkg::mem_req_t req,
  input logic              load_valid,
  input logic              tx_valid,
  input mem_pkg::wr_lane_t ram_lane
);
  timeunit 1ns;
  timeprecision 100ps;

  // One-cycle load return
  load_follows_re: assert property (
    @(posedge clk) disable iff (reset) req.re |=> load_valid
  ) else $error("load_valid missing one cycle after a load request");

  no_spurious_load: assert property (
    @(posedge clk) disable iff (reset) !req.re |=> !load_valid
  ) else $error("load_valid high without a load request");

  idle_after_reset: assert property (
    @(posedge clk) $fell(reset) |-> (!load_valid && !tx_valid)
  ) else $error("load_valid or tx_valid high right after reset");

  // RAM enables only on stores into the 1xxx_xxxx or 3xxx_xxxx window
  ram_write_needs_we: assert property (
    @(posedge clk) disable iff (reset)
    (ram_lane.be != 4'b0000) |->
      (req.we && (req.addr[31:28] == 4'h1 || req.addr[31:28] == 4'h3))
  ) else $error("data_ram byte enable set without a store to the data memory");

endmodule

bind mem_stage mem_stage_checker mem_stage_checker_inst (
  .clk       (clk),
  .reset     (reset),
  .req       (req),
  .load_valid(load_valid),
  .tx_valid  (tx_valid),
  .ram_lane  (ram_lane)
);

// File: tb/mem_stage_tb.sv
module mem_stage_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int dram_addr_width = 14;
  localparam int fifo_log_depth  = 5;
  localparam int fifo_depth      = 1 << fifo_log_depth;

  // Rough cycle budgets of the five tests
  localparam int t1_cycles    = 40;
  localparam int t2_cycles    = 60;
  localparam int t3_cycles    = 300;
  localparam int t4_cycles    = 250;
  localparam int t5_cycles    = 100;
  localparam int total_cycles = t1_cycles + t2_cycles + t3_cycles + t4_cycles + t5_cycles;

  typedef struct packed {
    logic        check;
    logic [31:0] value;
  } exp_t;

  logic                     clk;
  logic                     reset;
  mem_pkg::mem_req_t        req;
  logic [6:0]               opcode;
  logic [mem_pkg::xlen-1:0] load_data;
  logic                     load_valid;
  logic [7:0]               tx_data;
  logic                     tx_valid;
  logic                     tx_ready;
  logic [7:0]               rx_data;
  logic                     rx_valid;
  logic                     rx_ready;

  int          seed = 32'h704b3608;
  int          errors = 0;
  int          checks = 0;
  logic        tx_rand_en = 1'b0;
  logic [7:0]  shadow [0:65535];  // Byte image of the data memory
  exp_t        exp_q [$];
  logic [7:0]  tx_model [$];
  logic [7:0]  rx_model [$];

  mem_stage #(
    .dram_addr_width(dram_addr_width),
    .fifo_log_depth (fifo_log_depth)
  ) mem_stage_inst (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .opcode    (opcode),
    .load_data (load_data),
    .load_valid(load_valid),
    .tx_data   (tx_data),
    .tx_valid  (tx_valid),
    .tx_ready  (tx_ready),
    .rx_data   (rx_data),
    .rx_valid  (rx_valid),
    .rx_ready  (rx_ready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Expected load word from the byte image
  function automatic logic [31:0] expected_load(logic [31:0] addr, mem_pkg::funct3_t f3);
    logic [15:0] base;
    logic [31:0] w;
    logic [7:0]  b;
    logic [15:0] h;
    base = {addr[15:2], 2'b00};
    w = {shadow[base + 3], shadow[base + 2], shadow[base + 1], shadow[base]};
    b = shadow[addr[15:0]];
    h = addr[1] ? w[31:16] : w[15:0];  // Aligned half
    case (f3)
      mem_pkg::funct3_b:  return {{24{b[7]}}, b};
      mem_pkg::funct3_h:  return {{16{h[15]}}, h};
      mem_pkg::funct3_bu: return {24'd0, b};
      mem_pkg::funct3_hu: return {16'd0, h};
      default:            return w;
    endcase
  endfunction

  task automatic model_store(logic [31:0] addr, logic [31:0] data, mem_pkg::funct3_t f3);
    logic [15:0] idx;
    case (f3)
      mem_pkg::funct3_b: shadow[addr[15:0]] = data[7:0];
      mem_pkg::funct3_h: begin
        idx = {addr[15:2], addr[1], 1'b0};
        shadow[idx]     = data[7:0];
        shadow[idx + 1] = data[15:8];
      end
      default: begin
        idx = {addr[15:2], 2'b00};
        for (int i = 0; i < 4; i++) shadow[idx + i] = data[8*i +: 8];
      end
    endcase
  endtask

  task automatic drive_req(logic [31:0] addr, logic [31:0] data, mem_pkg::funct3_t f3,
                           logic we, logic re);
    @(posedge clk);
    req.addr   <= addr;
    req.wdata  <= data;
    req.funct3 <= f3;
    req.we     <= we;
    req.re     <= re;
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    req <= '0;
  endtask

  task automatic store(logic [31:0] addr, logic [31:0] data, mem_pkg::funct3_t f3);
    if (!addr[31]) model_store(addr, data, f3);
    drive_req(addr, data, f3, 1'b1, 1'b0);
  endtask

  task automatic load_check(logic [31:0] addr, mem_pkg::funct3_t f3, logic [31:0] value);
    exp_q.push_back('{check: 1'b1, value: value});
    drive_req(addr, 32'd0, f3, 1'b0, 1'b1);
  endtask

  // Load whose value the calling test inspects itself
  task automatic load_read(logic [31:0] addr, output logic [31:0] value);
    exp_q.push_back('{check: 1'b0, value: 32'd0});
    drive_req(addr, 32'd0, mem_pkg::funct3_w, 1'b0, 1'b1);
    idle_cycle();
    @(negedge clk);
    value = load_data;
  endtask

  function automatic logic [31:0] rand_dram_addr();
    logic [31:0] r;
    r = $random(seed);
    return {r[31] ? 4'h3 : 4'h1, 12'h000, r[15:2], 2'b00};
  endfunction

  // Load results are compared at the falling edge, where they are stable
  always @(negedge clk) begin
    exp_t e;
    if (!reset && load_valid) begin
      if (exp_q.size() == 0) begin
        $display("Time %0t: load_valid high with no load outstanding", $time);
        errors++;
      end else begin
        e = exp_q.pop_front();
        if (e.check) begin
          checks++;
          assert (load_data === e.value)
          else begin
            $display("MISMATCH time %0t load_data got %h expected %h", $time, load_data,
                     e.value);
            errors++;
          end
        end
      end
    end
  end

  always @(negedge clk) begin
    logic [7:0] b;
    if (!reset && tx_valid && tx_ready) begin
      if (tx_model.size() == 0) begin
        $display("Time %0t: tx sent a byte that was never stored", $time);
        errors++;
      end else begin
        b = tx_model.pop_front();
        checks++;
        assert (tx_data === b)
        else begin
          $display("MISMATCH time %0t tx_data got %h expected %h", $time, tx_data, b);
          errors++;
        end
      end
    end
  end

  always @(posedge clk) begin
    logic [31:0] r;
    r = $random(seed);
    tx_ready <= tx_rand_en ? r[0] : 1'b0;
  end

  initial begin
    repeat (total_cycles * 2) @(posedge clk);
    $display("Watchdog expired before the tests finished");
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    logic [31:0] addrs [16];
    logic [31:0] data;
    logic [31:0] value;
    logic [31:0] base;
    int          errs_before;
    int          polls;
    int          accepted;
    int          ops;
    int          lim;

    req      = '0;
    opcode   = 7'd0;
    tx_ready = 1'b0;
    rx_data  = 8'd0;
    rx_valid = 1'b0;
    reset    = 1'b1;
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    // Test 1, word stores then back-to-back word loads
    errs_before = errors;
    for (int i = 0; i < 16; i++) begin
      addrs[i] = rand_dram_addr();
      store(addrs[i], $random(seed), mem_pkg::funct3_w);
    end
    for (int i = 0; i < 16; i++) begin
      load_check(addrs[i], mem_pkg::funct3_w, expected_load(addrs[i], mem_pkg::funct3_w));
    end
    idle_cycle();
    idle_cycle();
    $display("Test 1 word store/load: %0d errors", errors - errs_before);

    // Test 2, sub-word stores and extended loads
    errs_before = errors;
    base = rand_dram_addr();
    store(base, $random(seed), mem_pkg::funct3_w);
    for (int off = 0; off < 4; off++) begin
      store(base + off, $random(seed), mem_pkg::funct3_b);
      load_check(base + off, mem_pkg::funct3_b, expected_load(base + off, mem_pkg::funct3_b));
      load_check(base + off, mem_pkg::funct3_bu, expected_load(base + off, mem_pkg::funct3_bu));
      load_check(base, mem_pkg::funct3_w, expected_load(base, mem_pkg::funct3_w));
    end
    for (int off = 0; off < 4; off += 2) begin
      store(base + off, $random(seed) | 32'h8000, mem_pkg::funct3_h);  // Negative half
      load_check(base + off, mem_pkg::funct3_h, expected_load(base + off, mem_pkg::funct3_h));
      load_check(base + off, mem_pkg::funct3_hu, expected_load(base + off, mem_pkg::funct3_hu));
      load_check(base, mem_pkg::funct3_w, expected_load(base, mem_pkg::funct3_w));
    end
    idle_cycle();
    idle_cycle();
    $display("Test 2 byte/half access: %0d errors", errors - errs_before);

    // Test 3, tx held off until the FIFO is full, then random back-pressure
    errs_before = errors;
    for (int i = 0; i < fifo_depth + 8; i++) begin
      if (i == fifo_depth) tx_rand_en = 1'b1;
      polls = 0;
      do begin
        load_read(mem_pkg::mmio_uart_ctrl, value);
        polls++;
      end while (!value[0] && polls < 50);
      assert (value[0])
      else begin
        $display("Time %0t: tx FIFO never reported room", $time);
        errors++;
      end
      data = $random(seed);
      tx_model.push_back(data[7:0]);
      store(mem_pkg::mmio_uart_tx, data, mem_pkg::funct3_b);
    end
    idle_cycle();
    lim = 0;
    while (tx_model.size() != 0 && lim < 200) begin
      @(posedge clk);
      lim++;
    end
    assert (tx_model.size() == 0)
    else begin
      $display("Time %0t: %0d tx bytes never came out", $time, tx_model.size());
      errors++;
    end
    tx_rand_en = 1'b0;
    $display("Test 3 tx stream: %0d errors", errors - errs_before);

    // Test 4, rx FIFO fills, then reads back in order
    errs_before = errors;
    accepted = 0;
    for (int i = 0; i < fifo_depth + 8; i++) begin
      @(posedge clk);
      data = $random(seed);
      rx_valid <= 1'b1;
      rx_data  <= data[7:0];
      @(negedge clk);
      if (!rx_ready) break;
      rx_model.push_back(data[7:0]);
      accepted++;
    end
    @(posedge clk);
    rx_valid <= 1'b0;
    assert (accepted == fifo_depth)
    else begin
      $display("Time %0t: rx_ready fell after %0d bytes instead of %0d", $time, accepted,
               fifo_depth);
      errors++;
    end
    while (rx_model.size() != 0) begin
      load_check(mem_pkg::mmio_uart_ctrl, mem_pkg::funct3_w, 32'h3);
      load_check(mem_pkg::mmio_uart_rx, mem_pkg::funct3_w, {24'd0, rx_model.pop_front()});
    end
    load_check(mem_pkg::mmio_uart_ctrl, mem_pkg::funct3_w, 32'h1);  // Nothing left
    idle_cycle();
    idle_cycle();
    $display("Test 4 rx stream: %0d errors", errors - errs_before);

    // Test 5, counters after a counter-reset store
    errs_before = errors;
    for (int j = 2; j < 20; j += 7) begin
      ops = 0;
      store(mem_pkg::mmio_cnt_reset, $random(seed), mem_pkg::funct3_w);
      for (int k = 1; k < j; k++) begin
        idle_cycle();
        data = $random(seed);
        opcode <= data[0] ? data[7:1] | 7'h01 : 7'd0;
        if (data[0]) ops++;
      end
      // Load j cycles after the store, opcode quiet from here on
      load_check(mem_pkg::mmio_cycle_cnt, mem_pkg::funct3_w, j - 1);
      opcode <= 7'd0;
      load_check(mem_pkg::mmio_inst_cnt, mem_pkg::funct3_w, ops);
      idle_cycle();
      idle_cycle();
    end
    $display("Test 5 counters: %0d errors", errors - errs_before);

    assert (exp_q.size() == 0)
    else begin
      $display("Time %0t: %0d loads never raised load_valid", $time, exp_q.size());
      errors++;
    end

    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: mem_stage.f
design/mem_pkg.sv
design/store_format.sv
design/data_ram.sv
design/byte_fifo.sv
design/mmio_regs.sv
design/load_align.sv
design/mem_stage.sv
tb/mem_stage_checker.sv
tb/mem_stage_tb.sv

// File: Bender.yml
package:
  name: mem_stage

sources:
  - design/mem_pkg.sv
  - design/store_format.sv
  - design/data_ram.sv
  - design/byte_fifo.sv
  - design/mmio_regs.sv
  - design/load_align.sv
  - design/mem_stage.sv
  - target: test
    files:
      - tb/mem_stage_checker.sv
      - tb/mem_stage_tb.sv
